//--- Makefile
VERILATOR ?= verilator
TOP ?= misc_alu_tb
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
BUILD_FLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "ALL CHECKS PASSED" $(LOG) || (echo "Simulation ended without a result"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- filelist.f
source/misc_pkg.sv
source/misc_stage_prepare.sv
source/misc_stage_finish.sv
source/misc_stage_select.sv
source/misc_alu.sv
tb/misc_alu_assert.sv
tb/misc_alu_tb.sv

//--- source/misc_alu.sv
`timescale 1ns/1ps

module misc_alu (
	input logic clk,
	input logic reset,
	input logic in_valid,
	output logic in_ready,
	input misc_pkg::misc_req_t req,
	output logic out_valid,
	input logic out_ready,
	output misc_pkg::misc_resp_t resp
);

	logic prep_valid;
	logic prep_ready;
	misc_pkg::misc_prep_t prep;
	logic fin_valid;
	logic fin_ready;
	misc_pkg::misc_fin_t fin;

	misc_stage_prepare stage_prepare (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.req(req),
		.out_valid(prep_valid),
		.out_ready(prep_ready),
		.prep(prep)
	);

	misc_stage_finish stage_finish (
		.clk(clk),
		.reset(reset),
		.in_valid(prep_valid),
		.in_ready(prep_ready),
		.prep(prep),
		.out_valid(fin_valid),
		.out_ready(fin_ready),
		.fin(fin)
	);

	misc_stage_select stage_select (
		.clk(clk),
		.reset(reset),
		.in_valid(fin_valid),
		.in_ready(fin_ready),
		.fin(fin),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.resp(resp)
	);

endmodule

//--- source/misc_pkg.sv
package misc_pkg;

	localparam int DATA_WIDTH = 16;
	localparam int WIDE_WIDTH = 32;

	typedef logic signed [DATA_WIDTH-1:0] data_t;
	typedef logic signed [WIDE_WIDTH-1:0] wide_t;
	typedef logic [3:0] shift_t;
	typedef logic [3:0] dest_t;
	typedef logic [3:0] misc_op_t;

	// Codes 9 to 15 are undefined and give a zero result.
	localparam misc_op_t OP_LSH      = 4'd0;
	localparam misc_op_t OP_RSH      = 4'd1;
	localparam misc_op_t OP_ABS      = 4'd2;
	localparam misc_op_t OP_MIN      = 4'd3;
	localparam misc_op_t OP_MAX      = 4'd4;
	localparam misc_op_t OP_CLAMP    = 4'd5;
	localparam misc_op_t OP_MOV_ACC  = 4'd6;
	localparam misc_op_t OP_MOV_LACC = 4'd7;
	localparam misc_op_t OP_MOV_UACC = 4'd8;

	// The first stage handles the shifts by 8 and 4, the second those by 2 and 1.
	localparam shift_t SHIFT_COARSE_MASK = 4'b1100;

	localparam wide_t SAT_MAX = 32'sd32767;
	localparam wide_t SAT_MIN = -32'sd32768;

	typedef struct packed {
		misc_op_t op;
		data_t    arg_a;
		data_t    arg_b;
		data_t    arg_c;
		wide_t    accumulator;
		shift_t   shift;
		logic     saturate_disable;
		dest_t    dest;
	} misc_req_t;

	typedef struct packed {
		misc_op_t op;
		data_t    lsh;
		data_t    rsh;
		wide_t    acc_shift;
		data_t    lower_acc;
		data_t    upper_acc;
		data_t    abs_val;
		data_t    min_val;
		data_t    max_val;
		data_t    clamp_val;
		data_t    clamp_lo;
		data_t    clamp_hi;
		shift_t   shift;
		logic     saturate_disable;
		dest_t    dest;
	} misc_prep_t;

	typedef struct packed {
		misc_op_t op;
		data_t    lsh;
		data_t    rsh;
		wide_t    acc_shift;
		data_t    lower_acc;
		data_t    upper_acc;
		data_t    abs_val;
		data_t    min_val;
		data_t    max_val;
		data_t    clamp_val;
		logic     saturate_disable;
		dest_t    dest;
	} misc_fin_t;

	typedef struct packed {
		wide_t result;
		dest_t dest;
	} misc_resp_t;

endpackage

//--- source/misc_stage_finish.sv
`timescale 1ns/1ps

module misc_stage_finish (
	input logic clk,
	input logic reset,
	input logic in_valid,
	output logic in_ready,
	input misc_pkg::misc_prep_t prep,
	output logic out_valid,
	input logic out_ready,
	output misc_pkg::misc_fin_t fin
);

	misc_pkg::shift_t fine;
	misc_pkg::data_t lsh_2;
	misc_pkg::data_t rsh_2;
	misc_pkg::wide_t acc_2;
	misc_pkg::misc_fin_t fin_next;
	logic take_in;

	assign in_ready = !out_valid || out_ready;
	assign take_in = in_valid && in_ready;

	assign fine = prep.shift & ~misc_pkg::SHIFT_COARSE_MASK;

	// The partial results from the first stage continue here, by 2 and then by 1.
	assign lsh_2 = fine[1] ? (prep.lsh << 2) : prep.lsh;
	assign rsh_2 = fine[1] ? (prep.rsh >> 2) : prep.rsh;
	assign acc_2 = fine[1] ? (prep.acc_shift >>> 2) : prep.acc_shift;

	always_comb begin
		fin_next.op = prep.op;
		fin_next.lsh = fine[0] ? (lsh_2 << 1) : lsh_2;
		fin_next.rsh = fine[0] ? (rsh_2 >> 1) : rsh_2;
		fin_next.acc_shift = fine[0] ? (acc_2 >>> 1) : acc_2;
		fin_next.lower_acc = prep.lower_acc;
		fin_next.upper_acc = prep.upper_acc;
		fin_next.abs_val = prep.abs_val;
		fin_next.min_val = prep.min_val;
		fin_next.max_val = prep.max_val;
		fin_next.clamp_val = (prep.clamp_val < prep.clamp_lo) ? prep.clamp_lo :
			((prep.clamp_val > prep.clamp_hi) ? prep.clamp_hi : prep.clamp_val);
		fin_next.saturate_disable = prep.saturate_disable;
		fin_next.dest = prep.dest;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
			fin <= '0;
		end else if (take_in) begin
			out_valid <= 1'b1;
			fin <= fin_next;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

endmodule

//--- source/misc_stage_prepare.sv
`timescale 1ns/1ps

module misc_stage_prepare (
	input logic clk,
	input logic reset,
	input logic in_valid,
	output logic in_ready,
	input misc_pkg::misc_req_t req,
	output logic out_valid,
	input logic out_ready,
	output misc_pkg::misc_prep_t prep
);

	misc_pkg::shift_t coarse;
	misc_pkg::data_t lsh_8;
	misc_pkg::data_t rsh_8;
	misc_pkg::wide_t acc_8;
	misc_pkg::misc_prep_t prep_next;
	logic clamp_swap;
	logic take_in;

	// The register slice can accept when it is empty or is being drained this cycle.
	assign in_ready = !out_valid || out_ready;
	assign take_in = in_valid && in_ready;

	assign coarse = req.shift & misc_pkg::SHIFT_COARSE_MASK;

	// First step of each shift, by 8 when bit 3 is set.
	assign lsh_8 = coarse[3] ? (req.arg_a << 8) : req.arg_a;
	assign rsh_8 = coarse[3] ? (req.arg_a >> 8) : req.arg_a;
	assign acc_8 = coarse[3] ? (req.accumulator >>> 8) : req.accumulator;

	assign clamp_swap = req.arg_c < req.arg_b;

	always_comb begin
		prep_next.op = req.op;

		// Second step, by 4 when bit 2 is set.
		prep_next.lsh = coarse[2] ? (lsh_8 << 4) : lsh_8;
		prep_next.rsh = coarse[2] ? (rsh_8 >> 4) : rsh_8;
		prep_next.acc_shift = coarse[2] ? (acc_8 >>> 4) : acc_8;

		prep_next.lower_acc = req.accumulator[misc_pkg::DATA_WIDTH-1:0];
		prep_next.upper_acc = req.accumulator[misc_pkg::WIDE_WIDTH-1:misc_pkg::DATA_WIDTH];

		// Negating -32768 wraps back to -32768 in 16 bits.
		prep_next.abs_val = (req.arg_a < 0) ? -req.arg_a : req.arg_a;
		prep_next.min_val = (req.arg_a < req.arg_b) ? req.arg_a : req.arg_b;
		prep_next.max_val = (req.arg_a > req.arg_b) ? req.arg_a : req.arg_b;

		// Bounds may arrive in either order.
		prep_next.clamp_val = req.arg_a;
		prep_next.clamp_lo = clamp_swap ? req.arg_c : req.arg_b;
		prep_next.clamp_hi = clamp_swap ? req.arg_b : req.arg_c;

		prep_next.shift = req.shift;
		prep_next.saturate_disable = req.saturate_disable;
		prep_next.dest = req.dest;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
			prep <= '0;
		end else if (take_in) begin
			out_valid <= 1'b1;
			prep <= prep_next;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

endmodule

//--- source/misc_stage_select.sv
`timescale 1ns/1ps

module misc_stage_select (
	input logic clk,
	input logic reset,
	input logic in_valid,
	output logic in_ready,
	input misc_pkg::misc_fin_t fin,
	output logic out_valid,
	input logic out_ready,
	output misc_pkg::misc_resp_t resp
);

	misc_pkg::wide_t value;
	misc_pkg::wide_t value_sat;
	misc_pkg::misc_resp_t resp_next;
	logic take_in;

	assign in_ready = !out_valid || out_ready;
	assign take_in = in_valid && in_ready;

	// The 16-bit operands are signed, so plain assignment sign-extends them.
	always_comb begin
		case (fin.op)
			misc_pkg::OP_LSH: value = fin.lsh;
			misc_pkg::OP_RSH: value = fin.rsh;
			misc_pkg::OP_ABS: value = fin.abs_val;
			misc_pkg::OP_MIN: value = fin.min_val;
			misc_pkg::OP_MAX: value = fin.max_val;
			misc_pkg::OP_CLAMP: value = fin.clamp_val;
			misc_pkg::OP_MOV_ACC: value = fin.acc_shift;
			misc_pkg::OP_MOV_LACC: value = fin.lower_acc;
			misc_pkg::OP_MOV_UACC: value = fin.upper_acc;
			default: value = '0;
		endcase
	end

	assign value_sat = (value < misc_pkg::SAT_MIN) ? misc_pkg::SAT_MIN :
		((value > misc_pkg::SAT_MAX) ? misc_pkg::SAT_MAX : value);

	always_comb begin
		resp_next.result = fin.saturate_disable ? value : value_sat;
		resp_next.dest = fin.dest;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
			resp <= '0;
		end else if (take_in) begin
			out_valid <= 1'b1;
			resp <= resp_next;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

endmodule

//--- tb/misc_alu_assert.sv
`timescale 1ns/1ps

module misc_alu_assert (
	input logic clk,
	input logic reset,
	input logic in_ready,
	input logic out_valid,
	input logic out_ready,
	input misc_pkg::misc_resp_t resp
);

	// A stalled response keeps both its valid and its payload.
	stall_holds: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(resp))
		else $error("Response changed while stalled");

	reset_clears: assert property (@(posedge clk) reset |=> !out_valid)
		else $error("out_valid high in the cycle after reset");

	// An empty output stage means nothing can block the input.
	empty_accepts: assert property (@(posedge clk) disable iff (reset)
		!out_valid |-> in_ready)
		else $error("in_ready low while out_valid is low");

endmodule

bind misc_alu misc_alu_assert handshake_checks (
	.clk(clk),
	.reset(reset),
	.in_ready(in_ready),
	.out_valid(out_valid),
	.out_ready(out_ready),
	.resp(resp)
);

//--- tb/misc_alu_tb.sv
`timescale 1ns/1ps

module misc_alu_tb;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 10;
	localparam int CYCLES_PER_TEST = 20;
	localparam int PIPE_LATENCY = 3;

	logic clk;
	logic reset;
	logic in_valid;
	logic in_ready;
	misc_pkg::misc_req_t req;
	logic out_valid;
	logic out_ready;
	misc_pkg::misc_resp_t resp;

	misc_pkg::misc_req_t test_reqs[$];
	misc_pkg::wide_t test_expected[$];
	string test_names[$];
	int seed;
	int passed;
	int errors;
	int received;
	logic latency_done;

	misc_alu dut (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.req(req),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.resp(resp)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// The dest tag of each request is its position in the table, modulo 16.
	task automatic add_test(input misc_pkg::misc_op_t op, input misc_pkg::data_t a,
		input misc_pkg::data_t b, input misc_pkg::data_t c, input misc_pkg::wide_t acc,
		input misc_pkg::shift_t shift, input logic sat_off, input misc_pkg::wide_t expected,
		input string name);
		misc_pkg::misc_req_t r;
		r.op = op;
		r.arg_a = a;
		r.arg_b = b;
		r.arg_c = c;
		r.accumulator = acc;
		r.shift = shift;
		r.saturate_disable = sat_off;
		r.dest = misc_pkg::dest_t'(test_reqs.size());
		test_reqs.push_back(r);
		test_expected.push_back(expected);
		test_names.push_back(name);
	endtask

	task automatic load_tests();
		add_test(misc_pkg::OP_LSH, 16'h0123, 16'h0000, 16'h0000, 32'h0000_0000, 4'd5, 1'b0,
			32'h0000_2460, "lsh_5");
		add_test(misc_pkg::OP_LSH, 16'h0001, 16'h0000, 16'h0000, 32'h0000_0000, 4'd15, 1'b0,
			32'hFFFF_8000, "lsh_15");
		add_test(misc_pkg::OP_RSH, 16'hFF00, 16'h0000, 16'h0000, 32'h0000_0000, 4'd0, 1'b0,
			32'hFFFF_FF00, "rsh_0");
		add_test(misc_pkg::OP_RSH, 16'h8000, 16'h0000, 16'h0000, 32'h0000_0000, 4'd5, 1'b0,
			32'h0000_0400, "rsh_5");
		add_test(misc_pkg::OP_RSH, 16'hFFFF, 16'h0000, 16'h0000, 32'h0000_0000, 4'd15, 1'b0,
			32'h0000_0001, "rsh_15");
		add_test(misc_pkg::OP_ABS, 16'hFFFB, 16'h0000, 16'h0000, 32'h0000_0000, 4'd0, 1'b0,
			32'h0000_0005, "abs_negative");
		add_test(misc_pkg::OP_ABS, 16'h8000, 16'h0000, 16'h0000, 32'h0000_0000, 4'd0, 1'b0,
			32'hFFFF_8000, "abs_most_negative");
		add_test(misc_pkg::OP_MIN, 16'hFFF9, 16'h0003, 16'h0000, 32'h0000_0000, 4'd0, 1'b0,
			32'hFFFF_FFF9, "min_signed");
		add_test(misc_pkg::OP_MAX, 16'hFFF9, 16'h0003, 16'h0000, 32'h0000_0000, 4'd0, 1'b0,
			32'h0000_0003, "max_signed");
		add_test(misc_pkg::OP_CLAMP, 16'h0064, 16'h0032, 16'h0050, 32'h0000_0000, 4'd0, 1'b0,
			32'h0000_0050, "clamp_ordered");
		add_test(misc_pkg::OP_CLAMP, 16'hFF9C, 16'h00C8, 16'hFFEC, 32'h0000_0000, 4'd0, 1'b0,
			32'hFFFF_FFEC, "clamp_swapped");
		add_test(misc_pkg::OP_MOV_ACC, 16'h0000, 16'h0000, 16'h0000, 32'h1234_5678, 4'd4, 1'b0,
			32'h0000_7FFF, "acc_saturated_high");
		add_test(misc_pkg::OP_MOV_ACC, 16'h0000, 16'h0000, 16'h0000, 32'h1234_5678, 4'd4, 1'b1,
			32'h0123_4567, "acc_raw_high");
		add_test(misc_pkg::OP_MOV_ACC, 16'h0000, 16'h0000, 16'h0000, 32'h8000_0000, 4'd15, 1'b0,
			32'hFFFF_8000, "acc_saturated_low");
		add_test(misc_pkg::OP_MOV_ACC, 16'h0000, 16'h0000, 16'h0000, 32'h8000_0000, 4'd15, 1'b1,
			32'hFFFF_0000, "acc_raw_low");
		add_test(misc_pkg::OP_MOV_LACC, 16'h0000, 16'h0000, 16'h0000, 32'h1234_8765, 4'd0, 1'b0,
			32'hFFFF_8765, "lower_acc");
		add_test(misc_pkg::OP_MOV_UACC, 16'h0000, 16'h0000, 16'h0000, 32'h1234_8765, 4'd0, 1'b0,
			32'h0000_1234, "upper_acc");
		add_test(4'd9, 16'h7FFF, 16'h0001, 16'h0002, 32'h7FFF_FFFF, 4'd3, 1'b1,
			32'h0000_0000, "undefined_9");
		add_test(4'd15, 16'h8000, 16'h8000, 16'h8000, 32'h8000_0000, 4'd15, 1'b0,
			32'h0000_0000, "undefined_15");
	endtask

	task automatic produce();
		int i;
		logic accepted;
		for (i = 0; i < test_reqs.size(); i++) begin
			@(negedge clk);
			in_valid = 1'b1;
			req = test_reqs[i];
			accepted = 1'b0;
			while (!accepted) begin
				@(posedge clk);
				accepted = in_ready;
			end
		end
		@(negedge clk);
		in_valid = 1'b0;
		req = '0;
	endtask

	task automatic check_response(input int idx, input misc_pkg::misc_resp_t got);
		if (got.result !== test_expected[idx]) begin
			$display("FAILED %s: expected %h, actual %h", test_names[idx],
				test_expected[idx], got.result);
			errors++;
		end else if (got.dest !== misc_pkg::dest_t'(idx)) begin
			$display("FAILED %s dest: expected %h, actual %h", test_names[idx],
				misc_pkg::dest_t'(idx), got.dest);
			errors++;
		end else begin
			$display("PASSED %s: %h", test_names[idx], got.result);
			passed++;
		end
	endtask

	// Ready stays high until the first response so that its latency is exact.
	task automatic consume();
		logic [31:0] rnd;
		while (received < test_reqs.size()) begin
			@(negedge clk);
			rnd = $random(seed);
			out_ready = (received == 0) ? 1'b1 : rnd[0];
			@(posedge clk);
			if (out_valid && out_ready) begin
				check_response(received, resp);
				received++;
			end
		end
	endtask

	task automatic check_idle();
		int extra;
		extra = 0;
		@(negedge clk);
		out_ready = 1'b1;
		repeat (2 * PIPE_LATENCY) begin
			@(posedge clk);
			if (out_valid) begin
				extra++;
			end
		end
		if (extra != 0) begin
			$display("Unexpected responses after the last test: %0d", extra);
			errors++;
		end
	endtask

	initial begin : first_latency
		int edge_count;
		int accept_edge;
		logic seen;
		edge_count = 0;
		accept_edge = -1;
		seen = 1'b0;
		@(negedge reset);
		while (!seen) begin
			@(posedge clk);
			edge_count++;
			if (accept_edge < 0 && in_valid && in_ready) begin
				accept_edge = edge_count;
			end
			seen = out_valid;
		end
		if (accept_edge < 0) begin
			$display("out_valid rose before the first request was accepted");
			errors++;
		end else if (edge_count - accept_edge != PIPE_LATENCY) begin
			$display("FAILED first_latency: expected %0d, actual %0d", PIPE_LATENCY,
				edge_count - accept_edge);
			errors++;
		end else begin
			$display("PASSED first_latency: %0d cycles", PIPE_LATENCY);
			passed++;
		end
		latency_done = 1'b1;
	end

	initial begin : watchdog
		#1;
		#(test_reqs.size() * CYCLES_PER_TEST * CLK_PERIOD);
		$display("Timeout: the pipeline stopped returning responses");
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin : main
		seed = 32'h739d_f142;
		clk = 1'b0;
		reset = 1'b1;
		in_valid = 1'b0;
		req = '0;
		out_ready = 1'b0;
		passed = 0;
		errors = 0;
		received = 0;
		latency_done = 1'b0;
		load_tests();
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;
		fork
			produce();
			consume();
		join
		wait (latency_done);
		check_idle();
		$display("Tests passed: %0d, failed: %0d", passed, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule
